/* logic/rtWrite_config.svh */
`ifndef RT_WRITE_CONFIG_SVH
`define RT_WRITE_CONFIG_SVH

// Number of DAC channels in one block
// Fixed by the 2-bit host slot address and the 4 amp mask bits
`define RT_NUM_DAC 4

// Clocks per strobe and per gap on the register bus
// Any value of 2 or more works
`define RT_GAP_CYCLES 4

// Power-control bits kept from the host quadlet
// Upper bits such as reboot requests are dropped
`define RT_CTRL_BITS 20

// Width of one DAC setpoint field
`define RT_SETPOINT_BITS 28

// Low nibble of a DAC channel register, channel n at (n+1)*16
`define RT_OFF_DAC_CTRL 4'h0

// Power-control register address
`define RT_ADDR_CTRL 8'h00

`endif

/* logic/rtWritePkg.sv */
`include "rtWrite_config.svh"

package rtWritePkg;

   // One host write, addr bit 2 selects the power-control quadlet
   typedef struct packed {
      logic        en;
      logic [3:0]  addr;
      logic [31:0] data;
   } rtHostWrite_t;

   // Local register bus between sequencer and register bank
   typedef struct packed {
      logic        writeEn;
      logic        blockStart;
      logic        regWen;
      logic        blockWen;
      logic [7:0]  regAddr;
      logic [31:0] regWdata;
   } rtRegBus_t;

   // DAC command view of a quadlet
   typedef struct packed {
      logic                         valid;
      logic                         spare;
      logic                         ampMask;
      logic                         ampState;
      logic [`RT_SETPOINT_BITS-1:0] setpoint;
   } rtDacCmd_t;

   // Power-control view, mask in ctrl[11:8] and state in ctrl[3:0]
   typedef struct packed {
      logic [31-`RT_CTRL_BITS:0]   unused;
      logic [`RT_CTRL_BITS-1:0]    ctrl;
   } rtPowerCtrl_t;

   // Same 32 bits, decoded by address
   typedef union packed {
      rtDacCmd_t    dacCmd;
      rtPowerCtrl_t powerCtrl;
   } rtQuadlet_u;

   // Sequencer states
   typedef enum logic [2:0] {
      idle,
      blockStart,
      dacWrite,
      dacGap,
      commitWait,
      ctrlGap,
      ctrlWrite
   } rtSeqState_t;

endpackage

/* logic/rtGapTimer.sv */
`include "rtWrite_config.svh"

module rtGapTimer (
   input  logic clk,
   input  logic rstN,
   input  logic restart,
   output logic done
);

   // Just wide enough for RT_GAP_CYCLES-1
   localparam int countBits = $clog2(`RT_GAP_CYCLES);

   logic [countBits-1:0] count;

   // Reload on restart, then count down to zero and hold there
   always_ff @(posedge clk)
   begin
      if (!rstN)
         count <= '0;
      else if (restart)
         count <= countBits'(`RT_GAP_CYCLES - 1);
      else if (count != '0)
         count <= count - 1'b1;
   end

   // Done sits high while idle at zero
   // High again RT_GAP_CYCLES clocks after a restart
   assign done = (count == '0);

   // A gap can never end right after it was started
   gapNotEarly: assert property (@(posedge clk) disable iff (!rstN)
      restart |=> !done)
      else $error("rtGapTimer done rose within a cycle of restart");

endmodule

/* logic/rtBlockStore.sv */
`include "rtWrite_config.svh"

module rtBlockStore (
   input  logic                    clk,
   input  logic                    rstN,
   input  rtWritePkg::rtHostWrite_t hostWr,
   input  logic                    busy,
   input  logic [1:0]              slot,
   input  logic                    clearSlot,
   input  logic                    clearCtrl,
   output logic                    trigger,
   output logic                    anyValid,
   output logic                    ctrlNonZero,
   output rtWritePkg::rtQuadlet_u  dacWord,
   output rtWritePkg::rtQuadlet_u  ctrlWord
);
   import rtWritePkg::*;

   rtQuadlet_u hostWord;
   // Spare bit and setpoint per slot
   logic [`RT_SETPOINT_BITS:0] payloadMem [`RT_NUM_DAC];
   logic [`RT_NUM_DAC-1:0]     validBits;
   logic [`RT_NUM_DAC-1:0]     maskBits;
   logic [`RT_NUM_DAC-1:0]     stateBits;
   logic [`RT_CTRL_BITS-1:0]   ctrlReg;
   logic                       accept;
   logic                       ctrlWrite;

   assign hostWord = hostWr.data;

   // Drop writes during a sequence, including the trigger cycle itself
   assign accept = hostWr.en && !busy && !trigger;
   assign ctrlWrite = accept && hostWr.addr[2];

   // DAC payload per slot
   always_ff @(posedge clk)
   begin
      if (accept && !hostWr.addr[2])
         payloadMem[hostWr.addr[1:0]] <= {hostWord.dacCmd.spare, hostWord.dacCmd.setpoint};
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         validBits <= '0;
         maskBits <= '0;
         stateBits <= '0;
         ctrlReg <= '0;
         trigger <= 1'b0;
      end
      else
      begin
         trigger <= ctrlWrite;
         if (accept && !hostWr.addr[2])
         begin
            validBits[hostWr.addr[1:0]] <= hostWord.dacCmd.valid;
            maskBits[hostWr.addr[1:0]] <= hostWord.dacCmd.ampMask;
            stateBits[hostWr.addr[1:0]] <= hostWord.dacCmd.ampState;
         end
         // Slot consumed by the sequencer
         if (clearSlot)
         begin
            validBits[slot] <= 1'b0;
            maskBits[slot] <= 1'b0;
            stateBits[slot] <= 1'b0;
         end
         // Fold amp mask and state from the DAC commands into the control word
         if (ctrlWrite)
            ctrlReg <= {hostWord.powerCtrl.ctrl[19:12], maskBits, 4'b0000, stateBits};
         else if (clearCtrl)
            ctrlReg <= '0;
      end
   end

   assign anyValid = |validBits;
   assign ctrlNonZero = |ctrlReg;

   // Word for the slot being sent
   always_comb
   begin
      dacWord.dacCmd.valid = validBits[slot];
      dacWord.dacCmd.spare = payloadMem[slot][`RT_SETPOINT_BITS];
      dacWord.dacCmd.ampMask = maskBits[slot];
      dacWord.dacCmd.ampState = stateBits[slot];
      dacWord.dacCmd.setpoint = payloadMem[slot][`RT_SETPOINT_BITS-1:0];
   end

   always_comb
   begin
      ctrlWord.powerCtrl.unused = '0;
      ctrlWord.powerCtrl.ctrl = ctrlReg;
   end

endmodule

/* logic/rtWriteSequencer.sv */
`include "rtWrite_config.svh"

module rtWriteSequencer (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   trigger,
   input  logic                   anyValid,
   input  logic                   ctrlNonZero,
   input  rtWritePkg::rtQuadlet_u dacWord,
   input  rtWritePkg::rtQuadlet_u ctrlWord,
   input  logic                   timerDone,
   output logic                   timerRestart,
   output logic [1:0]             slot,
   output logic                   clearSlot,
   output logic                   clearCtrl,
   output rtWritePkg::rtRegBus_t  regBus,
   output logic                   busy
);
   import rtWritePkg::*;

   rtSeqState_t state;
   rtSeqState_t nextState;
   rtQuadlet_u  dacOut;
   logic        lastSlot;
   logic [3:0]  chanNibble;

   assign lastSlot = (slot == 2'(`RT_NUM_DAC - 1));
   // Channel n lives at (n+1)*16
   assign chanNibble = 4'(slot) + 4'd1;

   // Next state, restart the gap timer on entry to every timed state
   always_comb
   begin
      nextState = state;
      timerRestart = 1'b0;
      case (state)
         idle:
         begin
            if (trigger && anyValid)
            begin
               nextState = blockStart;
               timerRestart = 1'b1;
            end
            else if (trigger)
               // Nothing to send to the DACs, go straight to the control write
               nextState = ctrlWrite;
         end
         blockStart:
         begin
            if (timerDone)
               nextState = dacWrite;
         end
         dacWrite:
         begin
            nextState = dacGap;
            timerRestart = 1'b1;
         end
         dacGap:
         begin
            if (timerDone && lastSlot)
            begin
               nextState = commitWait;
               timerRestart = 1'b1;
            end
            else if (timerDone)
               nextState = dacWrite;
         end
         commitWait:
         begin
            // Last cycle here carries blockWen
            if (timerDone && ctrlNonZero)
            begin
               nextState = ctrlGap;
               timerRestart = 1'b1;
            end
            else if (timerDone)
               nextState = idle;
         end
         ctrlGap:
         begin
            if (timerDone)
               nextState = ctrlWrite;
         end
         ctrlWrite:
            nextState = idle;
         default:
            nextState = idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state <= idle;
         slot <= 2'd0;
      end
      else
      begin
         state <= nextState;
         // Start every block at channel 0
         if (state == idle)
            slot <= 2'd0;
         else if (state == dacGap && timerDone && !lastSlot)
            slot <= slot + 2'd1;
      end
   end

   assign busy = (state != idle);
   assign clearSlot = (state == dacWrite);
   assign clearCtrl = (state == ctrlWrite);

   // DAC data goes out with its valid bit cleared
   always_comb
   begin
      dacOut = dacWord;
      dacOut.dacCmd.valid = 1'b0;
   end

   // Bus strobes decoded from state
   always_comb
   begin
      regBus = '0;
      regBus.writeEn = busy;
      regBus.blockStart = (state == blockStart);
      case (state)
         dacWrite:
         begin
            // Invalid channels get a slot on the bus but no strobe
            regBus.regWen = dacWord.dacCmd.valid;
            regBus.regAddr = {chanNibble, `RT_OFF_DAC_CTRL};
            regBus.regWdata = dacOut;
         end
         commitWait:
            regBus.blockWen = timerDone;
         ctrlWrite:
         begin
            // Quadlet write, regWen and blockWen together
            regBus.regWen = 1'b1;
            regBus.blockWen = 1'b1;
            regBus.regAddr = `RT_ADDR_CTRL;
            regBus.regWdata = ctrlWord;
         end
         default:
            regBus.regAddr = '0;
      endcase
   end

   // Register writes never overlap the block-start window
   noWenInStart: assert property (@(posedge clk) disable iff (!rstN)
      !(regBus.regWen && regBus.blockStart))
      else $error("rtWriteSequencer regWen during blockStart");

   // Commit strobe lasts one clock only
   blockWenPulse: assert property (@(posedge clk) disable iff (!rstN)
      regBus.blockWen |=> !regBus.blockWen)
      else $error("rtWriteSequencer blockWen held longer than one cycle");

endmodule

/* logic/dacRegBank.sv */
`include "rtWrite_config.svh"

module dacRegBank (
   input  logic                                         clk,
   input  logic                                         rstN,
   input  rtWritePkg::rtRegBus_t                        regBus,
   output logic [`RT_NUM_DAC-1:0][`RT_SETPOINT_BITS-1:0] setpoint,
   output logic [`RT_CTRL_BITS-1:0]                     powerCtrl,
   output logic [`RT_NUM_DAC-1:0]                       ampEnable
);
   import rtWritePkg::*;

   rtQuadlet_u                   busWord;
   logic [`RT_SETPOINT_BITS-1:0] shadow [`RT_NUM_DAC];
   logic [`RT_NUM_DAC-1:0]       pending;
   logic [3:0]                   chanField;
   logic [1:0]                   chan;
   logic                         dacHit;
   logic                         commitHit;
   logic                         ctrlHit;
   logic [`RT_NUM_DAC-1:0]       ampMask;
   logic [`RT_NUM_DAC-1:0]       ampState;

   assign busWord = regBus.regWdata;
   assign chanField = regBus.regAddr[7:4];
   assign chan = 2'(chanField - 4'd1);

   // Single DAC register write, channel field 1..RT_NUM_DAC
   assign dacHit = regBus.regWen && !regBus.blockWen &&
                   (regBus.regAddr[3:0] == `RT_OFF_DAC_CTRL) &&
                   (chanField != 4'd0) && (chanField <= `RT_NUM_DAC);
   // Block commit
   assign commitHit = regBus.blockWen && !regBus.regWen;
   // Power-control quadlet
   assign ctrlHit = regBus.regWen && regBus.blockWen && (regBus.regAddr == `RT_ADDR_CTRL);

   assign ampMask = busWord.powerCtrl.ctrl[11:8];
   assign ampState = busWord.powerCtrl.ctrl[3:0];

   // Staged setpoints
   always_ff @(posedge clk)
   begin
      if (dacHit)
         shadow[chan] <= busWord.dacCmd.setpoint;
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         setpoint <= '0;
         pending <= '0;
         powerCtrl <= '0;
         ampEnable <= '0;
      end
      else
      begin
         if (dacHit)
            pending[chan] <= 1'b1;
         // Apply all staged channels at once
         if (commitHit)
         begin
            for (int n = 0; n < `RT_NUM_DAC; n++)
            begin
               if (pending[n])
                  setpoint[n] <= shadow[n];
            end
            pending <= '0;
         end
         if (ctrlHit)
         begin
            powerCtrl <= busWord.powerCtrl.ctrl;
            // Only masked axes change
            ampEnable <= (ampEnable & ~ampMask) | (ampState & ampMask);
         end
      end
   end

   // Register strobes only inside a bus write window
   wenNeedsWriteEn: assert property (@(posedge clk) disable iff (!rstN)
      regBus.regWen |-> regBus.writeEn)
      else $error("dacRegBank regWen without writeEn");

endmodule

/* logic/rtWriteTop.sv */
`include "rtWrite_config.svh"

module rtWriteTop (
   input  logic                                         clk,
   input  logic                                         rstN,
   input  rtWritePkg::rtHostWrite_t                     hostWr,
   output logic                                         busy,
   output logic [`RT_NUM_DAC-1:0][`RT_SETPOINT_BITS-1:0] setpoint,
   output logic [`RT_CTRL_BITS-1:0]                     powerCtrl,
   output logic [`RT_NUM_DAC-1:0]                       ampEnable
);
   import rtWritePkg::*;

   logic       trigger;
   logic       anyValid;
   logic       ctrlNonZero;
   rtQuadlet_u dacWord;
   rtQuadlet_u ctrlWord;
   logic       timerRestart;
   logic       timerDone;
   logic [1:0] slot;
   logic       clearSlot;
   logic       clearCtrl;
   rtRegBus_t  regBus;

   // Host block storage
   rtBlockStore u_store (
      .clk         (clk),
      .rstN        (rstN),
      .hostWr      (hostWr),
      .busy        (busy),
      .slot        (slot),
      .clearSlot   (clearSlot),
      .clearCtrl   (clearCtrl),
      .trigger     (trigger),
      .anyValid    (anyValid),
      .ctrlNonZero (ctrlNonZero),
      .dacWord     (dacWord),
      .ctrlWord    (ctrlWord)
   );

   // Strobe and gap timing
   rtGapTimer u_timer (
      .clk     (clk),
      .rstN    (rstN),
      .restart (timerRestart),
      .done    (timerDone)
   );

   rtWriteSequencer u_seq (
      .clk          (clk),
      .rstN         (rstN),
      .trigger      (trigger),
      .anyValid     (anyValid),
      .ctrlNonZero  (ctrlNonZero),
      .dacWord      (dacWord),
      .ctrlWord     (ctrlWord),
      .timerDone    (timerDone),
      .timerRestart (timerRestart),
      .slot         (slot),
      .clearSlot    (clearSlot),
      .clearCtrl    (clearCtrl),
      .regBus       (regBus),
      .busy         (busy)
   );

   // Register bus receiver
   dacRegBank u_bank (
      .clk       (clk),
      .rstN      (rstN),
      .regBus    (regBus),
      .setpoint  (setpoint),
      .powerCtrl (powerCtrl),
      .ampEnable (ampEnable)
   );

endmodule

/* testbench/rtWriteTb.sv */
`include "rtWrite_config.svh"

module rtWriteTb;
   timeunit 1ns;
   timeprecision 100ps;
   import rtWritePkg::*;

   // Block counts for the run length
   localparam int numRandomBlocks = 12;
   localparam int numBlocks = numRandomBlocks + 8;
   // Host writes, trigger, longest sequence and the idle wait
   localparam int blockCycles = `RT_NUM_DAC * (`RT_GAP_CYCLES + 2) + 3 * `RT_GAP_CYCLES + 5;
   localparam int cycleLimit = 16 + numBlocks * blockCycles + 50;
   localparam logic [3:0] ctrlAddr = 4'b0100;

   logic                                          clk;
   logic                                          rstN;
   rtHostWrite_t                                  hostWr;
   logic                                          busy;
   logic [`RT_NUM_DAC-1:0][`RT_SETPOINT_BITS-1:0] setpoint;
   logic [`RT_CTRL_BITS-1:0]                      powerCtrl;
   logic [`RT_NUM_DAC-1:0]                        ampEnable;

   // Reference model state
   logic [`RT_NUM_DAC-1:0]                        mValid;
   logic [`RT_NUM_DAC-1:0]                        mMask;
   logic [`RT_NUM_DAC-1:0]                        mState;
   logic [`RT_NUM_DAC-1:0][`RT_SETPOINT_BITS-1:0] mSetpoint;
   logic                                          modelBusy;
   // Expected outputs after the running block
   logic [`RT_NUM_DAC-1:0][`RT_SETPOINT_BITS-1:0] expSetpoint;
   logic [`RT_CTRL_BITS-1:0]                      expPowerCtrl;
   logic [`RT_NUM_DAC-1:0]                        expAmpEnable;

   logic [31:0] lcgState;
   int          errCount = 0;
   int          cycleCount = 0;

   rtWriteTop u_dut (
      .clk       (clk),
      .rstN      (rstN),
      .hostWr    (hostWr),
      .busy      (busy),
      .setpoint  (setpoint),
      .powerCtrl (powerCtrl),
      .ampEnable (ampEnable)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Upper half of the LCG state since the low bits repeat too soon
   function automatic logic [15:0] lcgStep();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[31:16];
   endfunction

   function automatic logic [31:0] randWord();
      logic [15:0] hi;
      logic [15:0] lo;
      hi = lcgStep();
      lo = lcgStep();
      return {hi, lo};
   endfunction

   // One host quadlet with en high for a single cycle
   task automatic sendHost(input logic [3:0] addr, input logic [31:0] data);
      hostWr.en = 1'b1;
      hostWr.addr = addr;
      hostWr.data = data;
      @(posedge clk);
      #1;
      hostWr.en = 1'b0;
   endtask

   // Masked axes take their state bits and the others hold
   task automatic applyCtrl(input logic [`RT_CTRL_BITS-1:0] ctrl);
      expPowerCtrl = ctrl;
      for (int n = 0; n < `RT_NUM_DAC; n++)
      begin
         if (ctrl[8 + n])
            expAmpEnable[n] = ctrl[n];
      end
   endtask

   // DAC quadlet with valid in bit 31, spare 30, mask 29, state 28 and setpoint below
   task automatic writeDac(input logic [1:0] slot, input logic [31:0] word);
      if (!modelBusy)
      begin
         mValid[slot] = word[31];
         mMask[slot] = word[29];
         mState[slot] = word[28];
         mSetpoint[slot] = word[`RT_SETPOINT_BITS-1:0];
      end
      sendHost({2'b00, slot}, word);
   endtask

   // Control quadlet starts a block and sets the expected outputs
   task automatic writeCtrl(input logic [31:0] data);
      logic [`RT_CTRL_BITS-1:0] composed;
      if (!modelBusy)
      begin
         // Payload bits 19:12, amp mask in 11:8 and amp state in 3:0
         composed = '0;
         composed[19:12] = data[19:12];
         composed[11:8] = mMask;
         composed[3:0] = mState;
         if (|mValid)
         begin
            for (int n = 0; n < `RT_NUM_DAC; n++)
            begin
               if (mValid[n])
                  expSetpoint[n] = mSetpoint[n];
            end
            // Zero control word is skipped after a commit
            if (composed != '0)
               applyCtrl(composed);
            // Every slot passes the sequencer and is cleared
            mValid = '0;
            mMask = '0;
            mState = '0;
         end
         else
            applyCtrl(composed);
         modelBusy = 1'b1;
      end
      sendHost(ctrlAddr, data);
   endtask

   // Busy rises after the trigger, then falls at the end of the block
   task automatic waitIdle();
      while (!busy)
      begin
         @(posedge clk);
         #1;
      end
      while (busy)
      begin
         @(posedge clk);
         #1;
      end
      modelBusy = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic randomBlock(input logic forceValid);
      logic [31:0] word;
      for (int n = 0; n < `RT_NUM_DAC; n++)
      begin
         word = randWord();
         if (forceValid && n == 0)
            word[31] = 1'b1;
         writeDac(2'(n), word);
      end
      writeCtrl(randWord());
      waitIdle();
   endtask

   // Valid setpoints with no amp bits and zero payload bits
   task automatic zeroComposedBlock();
      for (int n = 0; n < `RT_NUM_DAC; n++)
         writeDac(2'(n), 32'h8000_0000 | (randWord() & 32'h0FFF_FFFF));
      writeCtrl(randWord() & 32'hFFF0_0FFF);
      waitIdle();
   endtask

   // Invalid DAC commands still carry amp mask and state
   task automatic invalidMaskBlock();
      for (int n = 0; n < `RT_NUM_DAC; n++)
         writeDac(2'(n), (randWord() & 32'h7FFF_FFFF) | 32'h2000_0000);
      writeCtrl(randWord());
      waitIdle();
   endtask

   // Writes during a sequence must leave the store alone
   task automatic busyWriteBlock();
      for (int n = 0; n < `RT_NUM_DAC; n++)
         writeDac(2'(n), randWord() | 32'h8000_0000);
      writeCtrl(randWord());
      while (!busy)
      begin
         @(posedge clk);
         #1;
      end
      for (int n = 0; n < `RT_NUM_DAC; n++)
         writeDac(2'(n), randWord() | 32'hA000_0000);
      writeCtrl(randWord());
      waitIdle();
   endtask

   initial
   begin
      rstN = 1'b0;
      hostWr = '0;
      lcgState = 32'd54;
      mValid = '0;
      mMask = '0;
      mState = '0;
      mSetpoint = '0;
      modelBusy = 1'b0;
      expSetpoint = '0;
      expPowerCtrl = '0;
      expAmpEnable = '0;
      repeat (16) @(posedge clk);
      #1;
      rstN = 1'b1;
      @(posedge clk);
      #1;
      for (int b = 0; b < numRandomBlocks; b++)
         randomBlock(1'b0);
      zeroComposedBlock();
      invalidMaskBlock();
      randomBlock(1'b1);
      // Control words alone on cleared slots
      writeCtrl(randWord());
      waitIdle();
      writeCtrl(randWord());
      waitIdle();
      busyWriteBlock();
      writeCtrl(randWord());
      waitIdle();
      writeCtrl(32'h0);
      waitIdle();
      $display("Errors: %0d", errCount);
      if (errCount == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // Run length guard
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= cycleLimit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
         $display("Errors: %0d", errCount);
         $display("TB FAILED");
         $finish;
      end
   end

   // Outputs cleared by reset
   resetClear: assert property (@(posedge clk)
      $rose(rstN) |-> (!busy && setpoint == '0 && powerCtrl == '0 && ampEnable == '0))
      else
      begin
         errCount++;
         $display("Fail reset busy %h setpoint %h powerCtrl %h ampEnable %h expected 0",
                  busy, setpoint, powerCtrl, ampEnable);
      end

   // Block results checked one clock after busy falls
   setpointCheck: assert property (@(posedge clk) disable iff (!rstN)
      $fell(busy) |-> (setpoint == expSetpoint))
      else
      begin
         errCount++;
         $display("Fail setpoint got %h expected %h", setpoint, expSetpoint);
      end

   powerCtrlCheck: assert property (@(posedge clk) disable iff (!rstN)
      $fell(busy) |-> (powerCtrl == expPowerCtrl))
      else
      begin
         errCount++;
         $display("Fail powerCtrl got %h expected %h", powerCtrl, expPowerCtrl);
      end

   ampEnableCheck: assert property (@(posedge clk) disable iff (!rstN)
      $fell(busy) |-> (ampEnable == expAmpEnable))
      else
      begin
         errCount++;
         $display("Fail ampEnable got %h expected %h", ampEnable, expAmpEnable);
      end

endmodule

/* flist.f */
+incdir+logic
logic/rtWritePkg.sv
logic/rtGapTimer.sv
logic/rtBlockStore.sv
logic/rtWriteSequencer.sv
logic/dacRegBank.sv
logic/rtWriteTop.sv
testbench/rtWriteTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module rtWriteTb -f flist.f \
   && ./obj_dir/VrtWriteTb > sim.log 2>&1 \
   || echo "Build or simulation run failed"

[ -f sim.log ] && cat sim.log

grep -q '^TB PASSED$' sim.log 2>/dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
